// ==== source/dram_fifo_pkg.sv ====
// --------------------
// widths, region sizes and the memory address type shared by the dual stream fifo
// import with dram_fifo_pkg::* in the module or interface header
// --------------------
`default_nettype none

package dram_fifo_pkg;

  // --------------------
  // stream and storage widths
  localparam int data_w          = 64;                 // stream payload
  localparam int mem_word_w      = data_w + 1;         // payload plus tlast

  // --------------------
  // memory layout, one region per channel
  localparam int region_depth    = 16;                 // words per channel
  localparam int offset_w        = $clog2(region_depth);
  localparam int num_channels    = 2;
  localparam int region_w        = $clog2(num_channels);
  localparam int addr_w          = region_w + offset_w; // flat word address
  localparam int mem_depth       = num_channels * region_depth;
  localparam int count_w         = offset_w + 1;       // occupancy 0..region_depth

  // --------------------
  // memory timing
  localparam int mem_wait_states = 2;                  // idle cycles before ack
  localparam int mem_wait_w      = $clog2(mem_wait_states + 1);

  // one address word, seen flat by the memory and split by the channels
  typedef union packed {
    logic [addr_w-1:0] flat;                           // memory index
    struct packed {
      logic [region_w-1:0] region;                     // channel select, msb
      logic [offset_w-1:0] offset;                     // ring position
    } field;
  } dram_addr_u;

endpackage

`default_nettype wire

// ==== source/wb_mem_if.sv ====
// --------------------
// wishbone classic link between a channel, the arbiter and the memory
// single transfers only, master holds cyc/stb and the request until ack
// --------------------
`timescale 1ns/10ps
`default_nettype none

interface wb_mem_if import dram_fifo_pkg::*; ();

  logic                  cyc;    // bus cycle in progress
  logic                  stb;    // transfer strobe
  logic                  we;     // 1 = write, 0 = read
  dram_addr_u            adr;    // word address
  logic [mem_word_w-1:0] dat_w;  // write data, master to slave
  logic [mem_word_w-1:0] dat_r;  // read data, valid with ack
  logic                  ack;    // one cycle, ends the transfer

  // channel side, or the arbiter toward the memory
  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output dat_w,
    input  dat_r,
    input  ack
  );

  // memory side, or the arbiter toward a channel
  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  dat_w,
    output dat_r,
    output ack
  );

endinterface

`default_nettype wire

// ==== source/stream_if.sv ====
// --------------------
// valid/ready stream of 64 bit beats with a tlast marker
// --------------------
`timescale 1ns/10ps
`default_nettype none

interface stream_if import dram_fifo_pkg::*; ();

  logic [data_w-1:0] tdata;
  logic              tlast;   // end of packet
  logic              tvalid;  // held with data until the beat moves
  logic              tready;  // sink can take a beat

  modport source (
    output tdata,
    output tlast,
    output tvalid,
    input  tready
  );

  modport sink (
    input  tdata,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

`default_nettype wire

// ==== source/fifo_channel.sv ====
// --------------------
// one ring buffer fifo channel that parks its beats in the channel's memory region
// input hold register -> wishbone write ... wishbone read -> output register
// --------------------
`timescale 1ns/10ps
`default_nettype none

module fifo_channel import dram_fifo_pkg::*; (
  input  wire                ddr3_axi_clk,
  input  wire                i_reset,
  input  wire [region_w-1:0] i_channel,  // memory region of this channel
  stream_if.sink             s_in,
  stream_if.source           s_out,
  wb_mem_if.master           m_bus
);

  // --------------------
  // state
  logic [data_w-1:0]   hold_data;       // beat waiting for its memory write
  logic                hold_last;
  logic                hold_valid;
  logic                hold_valid_nxt;
  logic                in_ready;        // registered and low through reset

  logic [data_w-1:0]   out_data;        // beat read back and offered downstream
  logic                out_last;
  logic                out_valid;

  logic [offset_w-1:0] wr_ptr;          // next ring slot to write
  logic [offset_w-1:0] rd_ptr;          // oldest stored word
  logic [count_w-1:0]  count;           // words held in memory

  logic                bus_cyc;         // transfer open on the bus
  logic                bus_we;          // direction of the open transfer
  dram_addr_u          bus_adr;
  logic [mem_word_w-1:0] bus_dat;       // write word frozen with the request
  logic                read_turn;       // read wins the next tie

  // --------------------
  // decode
  logic                in_fire;
  logic                out_fire;
  logic                wr_pend;
  logic                rd_pend;
  logic                do_read;
  logic                wr_done;
  logic                rd_done;
  dram_addr_u          wr_adr;
  dram_addr_u          rd_adr;

  assign in_fire  = s_in.tvalid && in_ready;
  assign out_fire = out_valid && s_out.tready;
  assign wr_pend  = hold_valid && (count < count_w'(region_depth));  // room left in region
  assign rd_pend  = (count != '0) && !out_valid;                      // stored and out empty
  assign do_read  = rd_pend && (!wr_pend || read_turn);               // alternate on a tie
  assign wr_done  = m_bus.ack && bus_we;
  assign rd_done  = m_bus.ack && !bus_we;

  // region bit on top of the ring pointer
  always_comb begin
    wr_adr.field.region = i_channel;
    wr_adr.field.offset = wr_ptr;
    rd_adr.field.region = i_channel;
    rd_adr.field.offset = rd_ptr;
  end

  // hold register empties only once its word is in memory
  always_comb begin
    hold_valid_nxt = hold_valid;
    if (in_fire) begin
      hold_valid_nxt = 1'b1;
    end else if (wr_done) begin
      hold_valid_nxt = 1'b0;
    end
  end

  // --------------------
  // control
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      hold_valid <= 1'b0;
      in_ready   <= 1'b0;
      out_valid  <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      bus_cyc    <= 1'b0;
      read_turn  <= 1'b0;
    end else begin
      hold_valid <= hold_valid_nxt;
      in_ready   <= !hold_valid_nxt;     // take a beat whenever the hold slot is free

      // ack closes the bus cycle and cyc stays low one cycle before the next
      if (bus_cyc) begin
        if (m_bus.ack) begin
          bus_cyc <= 1'b0;
        end
      end else if (wr_pend || rd_pend) begin
        bus_cyc   <= 1'b1;
        read_turn <= !do_read;           // other side gets the next tie
      end

      if (wr_done) begin
        wr_ptr <= wr_ptr + 1'b1;         // wraps inside the region
        count  <= count + 1'b1;
      end
      if (rd_done) begin
        rd_ptr <= rd_ptr + 1'b1;
        count  <= count - 1'b1;
      end

      if (rd_done) begin
        out_valid <= 1'b1;
      end else if (out_fire) begin
        out_valid <= 1'b0;
      end
    end
  end

  // --------------------
  // payload
  always_ff @(posedge ddr3_axi_clk) begin
    if (in_fire) begin
      hold_data <= s_in.tdata;
      hold_last <= s_in.tlast;
    end
    if (rd_done) begin
      out_data <= m_bus.dat_r[data_w-1:0];
      out_last <= m_bus.dat_r[data_w];
    end
    if (!bus_cyc) begin                  // request is frozen once cyc rises
      bus_we  <= !do_read;
      bus_adr <= do_read ? rd_adr : wr_adr;
      bus_dat <= {hold_last, hold_data};
    end
  end

  // --------------------
  // ports
  assign s_in.tready  = in_ready;
  assign s_out.tdata  = out_data;
  assign s_out.tlast  = out_last;
  assign s_out.tvalid = out_valid;

  assign m_bus.cyc    = bus_cyc;
  assign m_bus.stb    = bus_cyc;         // strobe follows cyc for single transfers
  assign m_bus.we     = bus_we;
  assign m_bus.adr    = bus_adr;
  assign m_bus.dat_w  = bus_dat;

  // --------------------
  // checks
  // request stays on the bus unchanged until the memory acks it
  a_req_held : assert property (@(posedge ddr3_axi_clk) disable iff (i_reset)
    m_bus.stb && !m_bus.ack |=> m_bus.stb && m_bus.cyc && $stable(m_bus.adr) &&
                                $stable(m_bus.we) && $stable(m_bus.dat_w));

  a_occupancy : assert property (@(posedge ddr3_axi_clk) disable iff (i_reset)
    count <= count_w'(region_depth));

endmodule

`default_nettype wire

// ==== source/wb_arbiter.sv ====
// --------------------
// round robin arbiter that lets two wishbone masters share one memory port
// grant is combinational and locked for the length of a bus cycle
// --------------------
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
  input  wire       ddr3_axi_clk,
  input  wire       i_reset,
  wb_mem_if.slave   s_ch0,
  wb_mem_if.slave   s_ch1,
  wb_mem_if.master  m_mem
);

  logic grant_q;     // owner of the open cycle
  logic grant_lock;  // keeps grant_q while a cycle is open
  logic prio;        // who wins when both ask (1 = ch1)
  logic sel;         // current grant (1 = ch1)

  // --------------------
  // grant
  always_comb begin
    if (grant_lock) begin
      sel = grant_q;                     // stay with the open cycle
    end else if (s_ch0.cyc && s_ch1.cyc) begin
      sel = prio;                        // rotate when both ask
    end else begin
      sel = s_ch1.cyc;                   // lone requester or ch0 when idle
    end
  end

  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      grant_q    <= 1'b0;
      grant_lock <= 1'b0;
      prio       <= 1'b0;
    end else begin
      grant_q    <= sel;
      grant_lock <= m_mem.cyc && !m_mem.ack;  // released on the ack edge
      if (m_mem.ack) begin
        prio <= !sel;                    // other master goes first next time
      end
    end
  end

  // --------------------
  // request mux toward memory
  assign m_mem.cyc   = sel ? s_ch1.cyc   : s_ch0.cyc;
  assign m_mem.stb   = sel ? s_ch1.stb   : s_ch0.stb;
  assign m_mem.we    = sel ? s_ch1.we    : s_ch0.we;
  assign m_mem.adr   = sel ? s_ch1.adr   : s_ch0.adr;
  assign m_mem.dat_w = sel ? s_ch1.dat_w : s_ch0.dat_w;

  // ack goes only to the owner and data is shared since it counts only with ack
  assign s_ch0.ack   = m_mem.ack && !sel;
  assign s_ch1.ack   = m_mem.ack && sel;
  assign s_ch0.dat_r = m_mem.dat_r;
  assign s_ch1.dat_r = m_mem.dat_r;

  // --------------------
  // checks
  a_one_ack : assert property (@(posedge ddr3_axi_clk) disable iff (i_reset)
    !(s_ch0.ack && s_ch1.ack));

endmodule

`default_nettype wire

// ==== source/dram_model.sv ====
// --------------------
// behavioral word memory on a wishbone slave port
// every transfer is acked after a fixed number of wait states
// --------------------
`timescale 1ns/10ps
`default_nettype none

module dram_model import dram_fifo_pkg::*; (
  input  wire      ddr3_axi_clk,
  input  wire      i_reset,
  wb_mem_if.slave  s_bus
);

  logic [mem_word_w-1:0] mem [mem_depth];  // both regions by flat index
  logic [mem_wait_w-1:0] wait_cnt;         // cycles of stb seen so far
  logic                  req;

  assign req = s_bus.cyc && s_bus.stb;

  // one cycle of ack in cycle mem_wait_states+1 of the transfer
  assign s_bus.ack   = req && (wait_cnt == mem_wait_w'(mem_wait_states));
  assign s_bus.dat_r = mem[s_bus.adr.flat];  // read data ready by ack

  // --------------------
  // wait state counter
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      wait_cnt <= '0;
    end else if (!req || s_bus.ack) begin
      wait_cnt <= '0;                      // restart for the next transfer
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // --------------------
  // storage
  always_ff @(posedge ddr3_axi_clk) begin
    if (s_bus.ack && s_bus.we) begin
      mem[s_bus.adr.flat] <= s_bus.dat_w;  // write lands on the ack edge
    end
  end

  // --------------------
  // checks
  a_ack_in_cycle : assert property (@(posedge ddr3_axi_clk) disable iff (i_reset)
    s_bus.ack |-> s_bus.cyc && s_bus.stb);

endmodule

`default_nettype wire

// ==== source/axis_dram_fifo_dual.sv ====
// --------------------
// dual channel stream fifo backed by one shared memory
// stream in -> channel 0 -> link -> channel 1 -> stream out
// --------------------
`timescale 1ns/10ps
`default_nettype none

module axis_dram_fifo_dual import dram_fifo_pkg::*; (
  input  wire              ddr3_axi_clk,
  input  wire              i_reset,
  // stream in
  input  wire [data_w-1:0] i_data,
  input  wire              i_last,
  input  wire              i_valid,
  output logic             o_in_ready,
  // stream out
  output logic [data_w-1:0] o_data,
  output logic              o_last,
  output logic              o_valid,
  input  wire               i_out_ready
);

  // --------------------
  // streams
  stream_if in_stream ();   // top inputs, into channel 0
  stream_if link ();        // channel 0 to channel 1
  stream_if out_stream ();  // channel 1 to top outputs

  assign in_stream.tdata  = i_data;
  assign in_stream.tlast  = i_last;
  assign in_stream.tvalid = i_valid;
  assign o_in_ready       = in_stream.tready;

  assign o_data            = out_stream.tdata;
  assign o_last            = out_stream.tlast;
  assign o_valid           = out_stream.tvalid;
  assign out_stream.tready = i_out_ready;

  // --------------------
  // memory buses
  wb_mem_if ch0_bus ();
  wb_mem_if ch1_bus ();
  wb_mem_if mem_bus ();

  fifo_channel u_ch0 (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (i_reset),
    .i_channel    (region_w'(0)),  // lower region
    .s_in         (in_stream),
    .s_out        (link),
    .m_bus        (ch0_bus)
  );

  fifo_channel u_ch1 (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (i_reset),
    .i_channel    (region_w'(1)),  // upper region
    .s_in         (link),
    .s_out        (out_stream),
    .m_bus        (ch1_bus)
  );

  wb_arbiter u_arbiter (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (i_reset),
    .s_ch0        (ch0_bus),
    .s_ch1        (ch1_bus),
    .m_mem        (mem_bus)
  );

  dram_model u_mem (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (i_reset),
    .s_bus        (mem_bus)
  );

endmodule

`default_nettype wire

// ==== tests/tb_dram_fifo.sv ====
// --------------------
// self checking random testbench for the dual channel stream fifo
// accepted input beats go into a queue model that checks every output beat
// --------------------
`timescale 1ns/10ps
`default_nettype none

module tb_dram_fifo import dram_fifo_pkg::*; ();

  localparam int max_cycles = 20000;     // about 4x the longest test
  localparam int capacity   = 36;        // 2 x (region + hold + output reg)

  logic              ddr3_axi_clk;
  logic              i_reset;
  logic [data_w-1:0] i_data;
  logic              i_last;
  logic              i_valid;
  logic              o_in_ready;
  logic [data_w-1:0] o_data;
  logic              o_last;
  logic              o_valid;
  logic              i_out_ready;

  logic [mem_word_w-1:0] model [$];      // expected beats as {tlast, tdata}
  logic [mem_word_w-1:0] expected;
  int                    errors;
  int                    in_count;       // beats accepted at the input
  int                    out_count;      // beats seen at the output
  int                    cycle_count;
  int                    start_count;
  logic                  in_fired;       // a beat moves on the coming edge
  string                 test_name;

  axis_dram_fifo_dual dut (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (i_reset),
    .i_data       (i_data),
    .i_last       (i_last),
    .i_valid      (i_valid),
    .o_in_ready   (o_in_ready),
    .o_data       (o_data),
    .o_last       (o_last),
    .o_valid      (o_valid),
    .i_out_ready  (i_out_ready)
  );

  // --------------------
  // clock and watchdog
  initial begin
    ddr3_axi_clk = 1'b0;
    forever #10 ddr3_axi_clk = !ddr3_axi_clk;
  end

  always @(posedge ddr3_axi_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout in %s after %0d cycles, the fifo stopped moving", test_name, cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // checks and monitor
  task automatic check_value(input string what, input logic [mem_word_w-1:0] exp_val,
                             input logic [mem_word_w-1:0] act_val);
    if (exp_val !== act_val) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
    end
  endtask

  // sampled mid cycle where inputs and outputs are both settled
  always @(negedge ddr3_axi_clk) begin
    in_fired = 1'b0;
    if (!i_reset) begin
      in_fired = i_valid && o_in_ready;
      if (in_fired) begin
        model.push_back({i_last, i_data});
        in_count++;
      end
      if (o_valid && i_out_ready) begin
        out_count++;
        if (model.size() == 0) begin
          errors++;
          $display("%s: output beat %h with nothing left in the model", test_name, o_data);
        end else begin
          expected = model.pop_front();
          check_value("beat", expected, {o_last, o_data});
        end
      end
    end
  end

  // --------------------
  // stimulus helpers
  task automatic next_cycle();
    @(posedge ddr3_axi_clk);
    #1;
  endtask

  task automatic new_beat(input int valid_pct);
    i_valid = ($urandom % 100) < valid_pct;
    i_data  = {$urandom, $urandom};
    i_last  = 1'($urandom % 2);
  endtask

  // push n beats in, holding each until it is taken
  task automatic send_beats(input int n, input int valid_pct, input int ready_pct);
    int target;
    target = in_count + n;
    while (in_count < target) begin
      if (!i_valid || in_fired) begin
        new_beat(valid_pct);
      end
      i_out_ready = ($urandom % 100) < ready_pct;
      next_cycle();
    end
    i_valid = 1'b0;
  endtask

  task automatic drain_output(input int ready_pct);
    while (model.size() != 0) begin
      i_out_ready = ($urandom % 100) < ready_pct;
      next_cycle();
    end
    check_value("o_valid after drain", '0, mem_word_w'(o_valid));  // nothing extra behind
  endtask

  // --------------------
  // test sequence
  initial begin
    void'($urandom(64651));
    i_reset     = 1'b1;
    i_data      = '0;
    i_last      = 1'b0;
    i_valid     = 1'b0;
    i_out_ready = 1'b0;
    in_fired    = 1'b0;
    errors      = 0;
    in_count    = 0;
    out_count   = 0;
    cycle_count = 0;

    test_name = "reset";
    repeat (2) begin
      next_cycle();
      check_value("o_valid", '0, mem_word_w'(o_valid));
    end
    i_reset = 1'b0;
    next_cycle();
    check_value("o_valid", '0, mem_word_w'(o_valid));
    check_value("o_in_ready", 1, mem_word_w'(o_in_ready));

    test_name = "stream";
    send_beats(300, 60, 50);
    drain_output(50);

    test_name = "capacity";
    i_out_ready = 1'b0;
    start_count = in_count;
    repeat (400) begin
      if (!i_valid || in_fired) begin
        new_beat(100);                   // offer every cycle
      end
      next_cycle();
    end
    i_valid = 1'b0;
    check_value("beats taken", mem_word_w'(capacity), mem_word_w'(in_count - start_count));
    check_value("o_in_ready", '0, mem_word_w'(o_in_ready));

    test_name = "drain";
    start_count = out_count;
    drain_output(100);
    check_value("beats out", mem_word_w'(capacity), mem_word_w'(out_count - start_count));

    test_name = "continuous";
    send_beats(500, 100, 100);
    drain_output(100);
    check_value("out vs in count", mem_word_w'(in_count), mem_word_w'(out_count));

    $display("%0d errors, %0d beats in, %0d beats out, %0d cycles",
             errors, in_count, out_count, cycle_count);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
source/dram_fifo_pkg.sv
source/wb_mem_if.sv
source/stream_if.sv
source/fifo_channel.sv
source/wb_arbiter.sv
source/dram_model.sv
source/axis_dram_fifo_dual.sv
tests/tb_dram_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the dual stream fifo testbench with verilator and run it
# exit status is 0 only when the pass message shows up in the output

verilator --binary --timing --assert -f compile.f \
  --top-module tb_dram_fifo -o sim_dram_fifo \
  && obj_dir/sim_dram_fifo | tee /dev/stderr | grep -q "^Testbench passed$" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }
